/* Bender.yml */
package:
  name: int_mul

sources:
  - files:
      - mul_pkg.sv
      - mul_ctrl.sv
      - mul_operand_prep.sv
      - mul_pp_tree.sv
      - mul_final_add.sv
      - int_mul_top.sv
  - target: test
    files:
      - int_mul_chk.sv
      - tb_int_mul.sv

/* int_mul_chk.sv */
// Timing checks for the integer multiply unit, bound into int_mul_top.
// Covers the accept to valid latency, the single-cycle valid pulse and the
// idle state after reset.

`timescale 1ns/10ps

module int_mul_chk (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_ena,
    input  logic i_busy,
    input  logic i_valid
);

    int fail_cnt = 0;

    a_latency: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_ena && !i_busy) |-> ##(mul_pkg::LAT) i_valid)
        else begin $error("valid missing LAT cycles after accept"); fail_cnt++; end

    a_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_valid |=> !i_valid)
        else begin $error("valid held longer than one cycle"); fail_cnt++; end

    // First edge with reset released
    a_reset_idle: assert property (@(posedge i_clk)
        $rose(i_nrst) |-> (!i_busy && !i_valid))
        else begin $error("busy or valid set right after reset"); fail_cnt++; end

endmodule

bind int_mul_top int_mul_chk u_chk (
    .i_clk(i_clk), .i_nrst(i_nrst), .i_ena(i_ena), .i_busy(o_busy),
    .i_valid(o_valid)
);

/* int_mul_top.sv */
// Integer multiply unit for a 64-bit RISC-V pipeline.
// Handles MUL, MULH, MULHU, MULHSU and MULW. Pulse i_ena with the flags and
// operands while o_busy is low; o_valid pulses four cycles later with the
// result on o_res, which then holds until the next result.

`timescale 1ns/10ps

module int_mul_top (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_ena,
    input  logic i_unsigned,
    input  logic i_hsu,
    input  logic i_high,
    input  logic i_rv32,
    input  logic [mul_pkg::XLEN-1:0] i_a1,
    input  logic [mul_pkg::XLEN-1:0] i_a2,
    output logic [mul_pkg::XLEN-1:0] o_res,
    output logic o_valid,
    output logic o_busy
);

    logic load;
    logic stg1;
    logic stg2;
    logic stg3;
    logic rv32_l;          // Flags as latched at accept
    logic unsigned_l;
    logic high_l;
    logic neg;
    logic [mul_pkg::XLEN-1:0] a1_c;
    logic [mul_pkg::XLEN-1:0] a2_c;
    logic [mul_pkg::LVL3_NUM-1:0][mul_pkg::LVL3_W-1:0] lvl3;

    mul_ctrl u_ctrl (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_ena(i_ena),
        .i_unsigned(i_unsigned), .i_high(i_high), .i_rv32(i_rv32),
        .o_load(load), .o_stg1(stg1), .o_stg2(stg2), .o_stg3(stg3),
        .o_rv32(rv32_l), .o_unsigned(unsigned_l), .o_high(high_l),
        .o_valid(o_valid), .o_busy(o_busy)
    );

    mul_operand_prep u_prep (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_load(load),
        .i_unsigned(i_unsigned), .i_hsu(i_hsu), .i_high(i_high), .i_rv32(i_rv32),
        .i_a1(i_a1), .i_a2(i_a2),
        .o_a1(a1_c), .o_a2(a2_c), .o_neg(neg)
    );

    mul_pp_tree u_tree (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_stg1(stg1), .i_stg2(stg2),
        .i_a1(a1_c), .i_a2(a2_c), .o_lvl3(lvl3)
    );

    mul_final_add u_final (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_stg3(stg3), .i_neg(neg),
        .i_rv32(rv32_l), .i_unsigned(unsigned_l), .i_high(high_l),
        .i_lvl3(lvl3), .o_res(o_res)
    );

endmodule

/* mul_ctrl.sv */
// Control for the multiply pipeline.
// Accepts a request when i_ena is seen with the unit idle, holds busy until
// the final stage and walks a one-hot token through the stage strobes.
// The formatting flags for the final stage are latched at accept.

`timescale 1ns/10ps

module mul_ctrl (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_ena,       // Request strobe
    input  logic i_unsigned,
    input  logic i_high,
    input  logic i_rv32,
    output logic o_load,      // Operands are taken at this edge
    output logic o_stg1,      // Partial products and level 1
    output logic o_stg2,      // Levels 2 and 3
    output logic o_stg3,      // Final add and format
    output logic o_rv32,
    output logic o_unsigned,
    output logic o_high,
    output logic o_valid,
    output logic o_busy
);

    logic accept;
    logic busy_q;
    logic [mul_pkg::LAT-1:0] stg_q;   // Bit n is set n+1 cycles after accept
    logic rv32_q;
    logic unsigned_q;
    logic high_q;

    // Requests while busy are simply lost
    assign accept = i_ena & ~busy_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy_q <= 1'b0;
            stg_q <= '0;
        end else begin
            stg_q <= {stg_q[mul_pkg::LAT-2:0], accept};
            if (accept) begin
                busy_q <= 1'b1;
            end else if (stg_q[mul_pkg::LAT-2]) begin
                busy_q <= 1'b0;           // Free again once the final stage runs
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rv32_q <= 1'b0;
            unsigned_q <= 1'b0;
            high_q <= 1'b0;
        end else if (accept) begin
            rv32_q <= i_rv32;
            unsigned_q <= i_unsigned;
            high_q <= i_high;
        end
    end

    assign o_load = accept;
    assign o_stg1 = stg_q[0];
    assign o_stg2 = stg_q[1];
    assign o_stg3 = stg_q[mul_pkg::LAT-2];
    assign o_valid = stg_q[mul_pkg::LAT-1];
    assign o_busy = busy_q;

    assign o_rv32 = rv32_q;
    assign o_unsigned = unsigned_q;
    assign o_high = high_q;

endmodule

/* mul_final_add.sv */
// Final stage of the multiplier.
// Adds the four level-3 sums into the 128-bit product, applies the 32-bit
// extension or the sign of the signed high-half forms, and keeps the result
// until the next operation reaches this stage. o_res is the upper or lower
// half of the stored word.

`timescale 1ns/10ps

module mul_final_add (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_stg3,
    input  logic i_neg,
    input  logic i_rv32,
    input  logic i_unsigned,
    input  logic i_high,
    input  logic [mul_pkg::LVL3_NUM-1:0][mul_pkg::LVL3_W-1:0] i_lvl3,
    output logic [mul_pkg::XLEN-1:0] o_res
);

    logic [mul_pkg::LVL3_W+15:0] lvl4_0;    // Digits of a2[31:0]
    logic [mul_pkg::LVL3_W+15:0] lvl4_1;    // Digits of a2[63:32]
    logic [mul_pkg::PROD_W-1:0] sum;
    logic [mul_pkg::PROD_W-1:0] fmt;
    logic ext;
    mul_pkg::mul_product_u prod_q;
    logic high_q;

    assign lvl4_0 = {i_lvl3[1], 16'h0000} + {16'h0000, i_lvl3[0]};
    assign lvl4_1 = {i_lvl3[3], 16'h0000} + {16'h0000, i_lvl3[2]};

    // Top bits of lvl4_1 are always zero, a1 times 32 bits fits in 96
    assign sum = {lvl4_1[mul_pkg::PROD_W-33:0], 32'h0000_0000}
               + {{(mul_pkg::PROD_W-mul_pkg::LVL3_W-16){1'b0}}, lvl4_0};

    assign ext = ~i_unsigned & sum[31];

    always_comb begin
        fmt = sum;
        if (i_rv32) begin
            fmt = {{(mul_pkg::PROD_W-32){ext}}, sum[31:0]};
        end else if (i_high && i_neg) begin
            fmt = -sum;                  // Exact negate, zero stays zero
        end
    end

    // High select is kept here so a new accept cannot disturb o_res
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            prod_q.word <= '0;
            high_q <= 1'b0;
        end else if (i_stg3) begin
            prod_q.word <= fmt;
            high_q <= i_high & ~i_rv32;
        end
    end

    assign o_res = high_q ? prod_q.half.hi : prod_q.half.lo;

endmodule

/* mul_operand_prep.sv */
// Operand conditioning for the multiplier.
// The array below only multiplies unsigned magnitudes, so signed high-half
// forms are turned into absolute values here and the sign of the product
// is kept in o_neg for the final stage. Everything is registered on i_load.

`timescale 1ns/10ps

module mul_operand_prep (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_load,
    input  logic i_unsigned,
    input  logic i_hsu,        // Signed a1 times unsigned a2
    input  logic i_high,
    input  logic i_rv32,
    input  logic [mul_pkg::XLEN-1:0] i_a1,
    input  logic [mul_pkg::XLEN-1:0] i_a2,
    output logic [mul_pkg::XLEN-1:0] o_a1,
    output logic [mul_pkg::XLEN-1:0] o_a2,
    output logic o_neg         // Product must be negated
);

    logic [mul_pkg::XLEN-1:0] abs1;
    logic [mul_pkg::XLEN-1:0] abs2;
    logic [mul_pkg::XLEN-1:0] a1_d;
    logic [mul_pkg::XLEN-1:0] a2_d;
    logic neg_d;
    logic ext1;
    logic ext2;

    // Most negative value maps onto itself, read back as 2**63 unsigned
    assign abs1 = i_a1[mul_pkg::XLEN-1] ? -i_a1 : i_a1;
    assign abs2 = i_a2[mul_pkg::XLEN-1] ? -i_a2 : i_a2;

    // Fill bits for the 32-bit forms
    assign ext1 = ~i_unsigned & i_a1[mul_pkg::XLEN/2-1];
    assign ext2 = ~i_unsigned & i_a2[mul_pkg::XLEN/2-1];

    always_comb begin
        a1_d = i_a1;
        a2_d = i_a2;
        neg_d = 1'b0;
        if (i_rv32) begin
            a1_d = {{(mul_pkg::XLEN/2){ext1}}, i_a1[mul_pkg::XLEN/2-1:0]};
            a2_d = {{(mul_pkg::XLEN/2){ext2}}, i_a2[mul_pkg::XLEN/2-1:0]};
        end else if (i_high && i_hsu) begin
            a1_d = abs1;                          // a2 stays raw
            neg_d = i_a1[mul_pkg::XLEN-1];
        end else if (i_high && !i_unsigned) begin
            a1_d = abs1;
            a2_d = abs2;
            neg_d = i_a1[mul_pkg::XLEN-1] ^ i_a2[mul_pkg::XLEN-1];
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_a1 <= '0;
            o_a2 <= '0;
            o_neg <= 1'b0;
        end else if (i_load) begin
            o_a1 <= a1_d;
            o_a2 <= a2_d;
            o_neg <= neg_d;
        end
    end

endmodule

/* mul_pkg.sv */
// Shared definitions for the 64-bit integer multiply unit.
// Holds the word and product widths, the adder tree sizes, the pipeline
// latency and the stored product word. RTL, checker and testbench refer
// to these by scoped name only.

package mul_pkg;

    // Architectural word, used for both operands and the result
    localparam int XLEN = 64;

    // Full product of two words
    localparam int PROD_W = 2 * XLEN;

    localparam int PP_NUM = XLEN / 2;      // One per radix-4 digit of a2
    localparam int LVL1_NUM = PP_NUM / 2;  // Pair sums after level 1
    localparam int LVL3_NUM = 4;           // Registered sums handed to the final stage
    localparam int LVL3_W = 82;            // Room for a1 times a 16-bit slice of a2

    // Accepting edge to valid
    localparam int LAT = 4;

    // Finished product. The whole word is used when negating or
    // extending, the halves when the result is picked out.
    typedef union packed {
        logic [PROD_W-1:0] word;
        struct packed {
            logic [XLEN-1:0] hi;
            logic [XLEN-1:0] lo;
        } half;
    } mul_product_u;

endpackage

/* mul_pp_tree.sv */
// Radix-4 partial products and the first three adder levels.
// Stage 1 picks 0, a1, 2*a1 or 3*a1 for every two-bit digit of a2 and
// adds neighbouring pairs. Stage 2 adds pairs twice more with 4 and 8 bit
// shifts. Each sum n covers digits of a2 starting at bit position n times
// its group size, so the final stage only has to shift and add four words.

`timescale 1ns/10ps

module mul_pp_tree (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_stg1,
    input  logic i_stg2,
    input  logic [mul_pkg::XLEN-1:0] i_a1,
    input  logic [mul_pkg::XLEN-1:0] i_a2,
    output logic [mul_pkg::LVL3_NUM-1:0][mul_pkg::LVL3_W-1:0] o_lvl3
);

    // Up to 3*a1
    logic [mul_pkg::XLEN+1:0] pp [mul_pkg::PP_NUM];
    // Up to a1 times a 4-bit slice
    logic [mul_pkg::XLEN+3:0] lvl1_d [mul_pkg::LVL1_NUM];
    logic [mul_pkg::XLEN+3:0] lvl1_q [mul_pkg::LVL1_NUM];
    // Up to a1 times an 8-bit slice
    logic [mul_pkg::XLEN+7:0] lvl2 [mul_pkg::LVL1_NUM/2];
    logic [mul_pkg::LVL3_NUM-1:0][mul_pkg::LVL3_W-1:0] lvl3_d;

    // Digit select
    always_comb begin
        for (int i = 0; i < mul_pkg::PP_NUM; i++) begin
            case (i_a2[2*i +: 2])
                2'd0: pp[i] = '0;
                2'd1: pp[i] = {2'b00, i_a1};
                2'd2: pp[i] = {1'b0, i_a1, 1'b0};
                default: pp[i] = {2'b00, i_a1} + {1'b0, i_a1, 1'b0};
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < mul_pkg::LVL1_NUM; i++) begin
            lvl1_d[i] = {pp[2*i+1], 2'b00} + {2'b00, pp[2*i]};
        end
    end

    // Level 2 feeds straight into level 3 within one cycle
    always_comb begin
        for (int i = 0; i < mul_pkg::LVL1_NUM/2; i++) begin
            lvl2[i] = {lvl1_q[2*i+1], 4'b0000} + {4'b0000, lvl1_q[2*i]};
        end
        for (int i = 0; i < mul_pkg::LVL3_NUM; i++) begin
            lvl3_d[i] = {{(mul_pkg::LVL3_W-mul_pkg::XLEN-16){1'b0}}, lvl2[2*i+1], 8'h00}
                      + {{(mul_pkg::LVL3_W-mul_pkg::XLEN-8){1'b0}}, lvl2[2*i]};
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < mul_pkg::LVL1_NUM; i++) begin
                lvl1_q[i] <= '0;
            end
        end else if (i_stg1) begin
            for (int i = 0; i < mul_pkg::LVL1_NUM; i++) begin
                lvl1_q[i] <= lvl1_d[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_lvl3 <= '0;
        end else if (i_stg2) begin
            o_lvl3 <= lvl3_d;
        end
    end

endmodule

/* tb.f */
mul_pkg.sv
mul_ctrl.sv
mul_operand_prep.sv
mul_pp_tree.sv
mul_final_add.sv
int_mul_top.sv
int_mul_chk.sv
tb_int_mul.sv

/* tb_int_mul.sv */
// Testbench for int_mul_top.
// Sends random MUL, MULH, MULHU, MULHSU and MULW requests, first at the
// fastest rate and then with gaps, and checks every result against a
// 128-bit reference model. Requests during busy are dropped by the model.

`timescale 1ns/10ps

module tb_int_mul;

    typedef enum int {OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU, OP_MULW, OP_MULWU} op_e;

    logic i_clk = 1'b0;
    logic i_nrst;
    logic i_ena;
    logic i_unsigned;
    logic i_hsu;
    logic i_high;
    logic i_rv32;
    logic [mul_pkg::XLEN-1:0] i_a1;
    logic [mul_pkg::XLEN-1:0] i_a2;
    logic [mul_pkg::XLEN-1:0] o_res;
    logic o_valid;
    logic o_busy;

    int num_req = 300;      // Accepted requests in the whole run
    int err_cnt = 0;
    int n_acc = 0;
    int n_valid = 0;
    int busy_left = 0;      // Edges the model still sees busy
    int edge_cnt = 0;
    bit checking = 1'b0;
    logic [mul_pkg::XLEN-1:0] last_res = '0;
    logic [mul_pkg::XLEN-1:0] exp_q[$];
    int edge_q[$];

    int_mul_top uut (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_ena(i_ena), .i_unsigned(i_unsigned),
        .i_hsu(i_hsu), .i_high(i_high), .i_rv32(i_rv32), .i_a1(i_a1), .i_a2(i_a2),
        .o_res(o_res), .o_valid(o_valid), .o_busy(o_busy)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) edge_cnt <= edge_cnt + 1;

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("Fail %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // Corner values are favoured over plain random words
    function automatic logic [63:0] pick_operand();
        int sel;
        sel = $urandom_range(15);
        case (sel)
            0: return '0;
            1: return '1;
            2: return 64'h8000_0000_0000_0000;
            3: return {$urandom(), 32'h0000_0000};
            4: return 64'h7fff_ffff_ffff_ffff;
            5: return {32'h0000_0000, $urandom()};
            default: return {$urandom(), $urandom()};
        endcase
    endfunction

    function automatic logic [63:0] model_result(input op_e op, input logic [63:0] a1,
                                                 input logic [63:0] a2);
        logic [127:0] x1;
        logic [127:0] x2;
        logic [127:0] p;
        x1 = {{64{a1[63]}}, a1};            // Signed by default
        x2 = {{64{a2[63]}}, a2};
        if (op == OP_MUL || op == OP_MULHU) begin
            x1 = {64'h0, a1};
            x2 = {64'h0, a2};
        end else if (op == OP_MULHSU) begin
            x2 = {64'h0, a2};
        end else if (op == OP_MULW) begin
            x1 = {{96{a1[31]}}, a1[31:0]};
            x2 = {{96{a2[31]}}, a2[31:0]};
        end else if (op == OP_MULWU) begin
            x1 = {96'h0, a1[31:0]};
            x2 = {96'h0, a2[31:0]};
        end
        p = x1 * x2;                        // Low 128 bits are exact either way
        case (op)
            OP_MUL: return p[63:0];
            OP_MULW: return {{32{p[31]}}, p[31:0]};
            OP_MULWU: return {32'h0, p[31:0]};
            default: return p[127:64];
        endcase
    endfunction

    // One cycle of stimulus, driven just after the rising edge
    task automatic drive_cycle(input bit ena, input op_e op, input logic [63:0] a1,
                               input logic [63:0] a2);
        bit acc;
        @(posedge i_clk);
        #2;
        check_val("o_busy", busy_left > 0, o_busy);
        i_ena = ena;
        i_a1 = a1;
        i_a2 = a2;
        i_high = (op == OP_MULH || op == OP_MULHU || op == OP_MULHSU);
        i_unsigned = (op == OP_MULHU || op == OP_MULWU);
        i_hsu = (op == OP_MULHSU);
        i_rv32 = (op == OP_MULW || op == OP_MULWU);
        acc = 1'b0;
        if (busy_left > 0) begin
            busy_left--;                    // Dropped while busy
        end else begin
            acc = ena;
        end
        if (acc) begin
            exp_q.push_back(model_result(op, a1, a2));
            edge_q.push_back(edge_cnt + 1);
            n_acc++;
            busy_left = mul_pkg::LAT - 1;   // Busy until the final stage edge
        end
    endtask

    task automatic run_requests(input int count, input int ena_pct);
        int target;
        target = n_acc + count;
        while (n_acc < target) begin
            drive_cycle($urandom_range(99) < ena_pct, op_e'($urandom_range(5)),
                        pick_operand(), pick_operand());
        end
        drive_cycle(1'b0, OP_MUL, '0, '0);
    endtask

    // Outputs are read at the falling edge, away from any update
    always @(negedge i_clk) begin
        if (checking) begin
            if (o_valid) begin
                n_valid++;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("o_valid pulsed with no accepted request outstanding");
                end else begin
                    check_val("o_res", exp_q.pop_front(), o_res);
                    // Valid is sampled at the next rising edge
                    check_val("valid latency", mul_pkg::LAT, edge_cnt + 1 - edge_q.pop_front());
                    last_res = o_res;
                end
            end else begin
                check_val("o_res held", last_res, o_res);
            end
        end
    end

    initial begin
        repeat (num_req * 6 + 100) @(posedge i_clk);
        $display("Timed out with %0d of %0d results seen", n_valid, n_acc);
        $display("Errors: %0d", err_cnt + uut.u_chk.fail_cnt);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hc4ab_a210));
        i_nrst = 1'b0;
        i_ena = 1'b0;
        i_unsigned = 1'b0;
        i_hsu = 1'b0;
        i_high = 1'b0;
        i_rv32 = 1'b0;
        i_a1 = '0;
        i_a2 = '0;
        repeat (8) @(posedge i_clk);
        #2 i_nrst = 1'b1;
        @(negedge i_clk);
        check_val("o_valid", 1'b0, o_valid);
        check_val("o_busy", 1'b0, o_busy);
        check_val("o_res", '0, o_res);
        checking = 1'b1;

        run_requests(40, 100);              // Back to back at the fastest rate
        run_requests(num_req - 40, 70);
        wait (n_valid == n_acc);
        repeat (mul_pkg::LAT + 2) @(posedge i_clk);
        check_val("valid pulse count", n_acc, n_valid);

        $display("Requests: %0d, errors: %0d, assertion failures: %0d",
                 n_acc, err_cnt, uut.u_chk.fail_cnt);
        if (err_cnt + uut.u_chk.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
